// ==== datapath_cfg.svh ====
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// --------------------------------------------------
// datapath sizing
// --------------------------------------------------

`define WORD_W    32  // bus, register and MAR width
`define REG_COUNT 16  // general registers R0..R15
`define REG_IDX_W 4   // ra/rb/rc field width

// the IR layout below assumes a 5-bit opcode in the top bits

`endif

// ==== datapathPkg.sv ====
`include "datapath_cfg.svh"

package datapathPkg;

	// --------------------------------------------------
	// ALU operation codes, same values as the opcode field
	// --------------------------------------------------
	typedef enum logic [4:0] {
		aluAdd  = 5'b00011,
		aluSub  = 5'b00100,
		aluAnd  = 5'b00101,
		aluOr   = 5'b00110,
		aluShr  = 5'b00111,
		aluShra = 5'b01000,
		aluShl  = 5'b01001,
		aluRor  = 5'b01010,
		aluRol  = 5'b01011,
		aluMul  = 5'b01111,
		aluNeg  = 5'b10001,
		aluNot  = 5'b10010
	} aluOpT;

	// --------------------------------------------------
	// IR word, register form and immediate form
	// --------------------------------------------------
	typedef union packed {
		struct packed {
			logic [4:0]                            opcode;
			logic [`REG_IDX_W-1:0]                 ra;
			logic [`REG_IDX_W-1:0]                 rb;
			logic [`REG_IDX_W-1:0]                 rc;
			logic [`WORD_W-5-3*`REG_IDX_W-1:0]     unused;
		} regForm;
		struct packed {
			logic [4:0]                            opcode;
			logic [`REG_IDX_W-1:0]                 ra;
			logic [`REG_IDX_W-1:0]                 rb;
			logic [`WORD_W-5-2*`REG_IDX_W-1:0]     c;  // signed constant
		} immForm;
	} instrT;

endpackage

// ==== regBusIf.sv ====
`timescale 1ns/1ps
`include "datapath_cfg.svh"

interface regBusIf import datapathPkg::*; ();

	instrT              ir;          // current IR, both decodings
	logic [`WORD_W-1:0] busValue;    // word on the shared bus
	logic [`WORD_W-1:0] regValue;    // register or constant offered
	logic               regDrive;    // rOut or baOut active
	logic               constDrive;  // cOut active

	// --------------------------------------------------
	// register file side
	// --------------------------------------------------
	modport regSide (
		input  ir,
		input  busValue,
		output regValue,
		output regDrive,
		output constDrive
	);

	// --------------------------------------------------
	// bus unit side
	// --------------------------------------------------
	modport busSide (
		output ir,
		output busValue,
		input  regValue,
		input  regDrive,
		input  constDrive
	);

endinterface

// ==== regFile.sv ====
`timescale 1ns/1ps
`include "datapath_cfg.svh"

module regFile import datapathPkg::*; (
	input  logic     Clock,
	input  logic     rstN,
	input  logic     gra,
	input  logic     grb,
	input  logic     grc,
	input  logic     rIn,
	input  logic     rOut,
	input  logic     baOut,
	input  logic     cOut,
	regBusIf.regSide regBus
);

	logic [`WORD_W-1:0]    regs [`REG_COUNT];
	logic [`REG_IDX_W-1:0] regIdx;
	logic [`WORD_W-1:0]    selValue;
	logic [`WORD_W-1:0]    constValue;

	// --------------------------------------------------
	// select and encode
	// --------------------------------------------------
	assign regIdx = ({`REG_IDX_W{gra}} & regBus.ir.regForm.ra)
		| ({`REG_IDX_W{grb}} & regBus.ir.regForm.rb)
		| ({`REG_IDX_W{grc}} & regBus.ir.regForm.rc);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[regIdx] <= regBus.busValue;
		end
	end

	assign selValue = (baOut && regIdx == '0) ? '0 : regs[regIdx];  // R0 as base reads zero
	assign constValue = `WORD_W'(signed'(regBus.ir.immForm.c));  // sign extend c

	always_comb begin
		if (cOut) begin
			regBus.regValue = constValue;
		end else if (rOut || baOut) begin
			regBus.regValue = selValue;
		end else begin
			regBus.regValue = '0;
		end
	end

	assign regBus.regDrive = rOut | baOut;
	assign regBus.constDrive = cOut;

	// a register access needs a single decoded field
	selOneField: assert property (@(posedge Clock) disable iff (!rstN)
		(rIn || rOut) |-> $onehot0({gra, grb, grc}));

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps
`include "datapath_cfg.svh"

module alu import datapathPkg::*; (
	input  logic [`WORD_W-1:0]   a,       // Y
	input  logic [`WORD_W-1:0]   b,       // bus
	input  aluOpT                op,
	output logic [2*`WORD_W-1:0] result
);

	localparam int SHIFT_W = $clog2(`WORD_W);
	localparam int PROD_W = 2 * `WORD_W;

	logic [SHIFT_W-1:0] shamt;
	logic [`WORD_W-1:0] low;
	logic [PROD_W-1:0]  product;

	assign shamt = b[SHIFT_W-1:0];

	// --------------------------------------------------
	// single word operations
	// --------------------------------------------------
	always_comb begin
		case (op)
			aluAdd: begin
				low = a + b;
			end
			aluSub: begin
				low = a - b;
			end
			aluAnd: begin
				low = a & b;
			end
			aluOr: begin
				low = a | b;
			end
			aluShr: begin
				low = a >> shamt;
			end
			aluShra: begin
				low = signed'(a) >>> shamt;  // keeps sign bit
			end
			aluShl: begin
				low = a << shamt;
			end
			aluRor: begin
				low = (a >> shamt) | (a << (`WORD_W - shamt));
			end
			aluRol: begin
				low = (a << shamt) | (a >> (`WORD_W - shamt));
			end
			aluNeg: begin
				low = -b;
			end
			aluNot: begin
				low = ~b;
			end
			default: begin
				low = '0;
			end
		endcase
	end

	// --------------------------------------------------
	// signed multiply, full width
	// --------------------------------------------------
	assign product = PROD_W'(signed'(a)) * PROD_W'(signed'(b));

	assign result = (op == aluMul) ? product : {`WORD_W'(0), low};

endmodule

// ==== busUnit.sv ====
`timescale 1ns/1ps
`include "datapath_cfg.svh"

module busUnit import datapathPkg::*; (
	input  logic               Clock,
	input  logic               rstN,
	input  logic               pcOut,
	input  logic               zHighOut,
	input  logic               zLowOut,
	input  logic               mdrOut,
	input  logic               hiOut,
	input  logic               loOut,
	input  logic               pcIn,
	input  logic               irIn,
	input  logic               marIn,
	input  logic               mdrIn,
	input  logic               yIn,
	input  logic               hiIn,
	input  logic               loIn,
	input  logic               zIn,
	input  logic               incPc,
	input  logic               read,
	input  aluOpT              op,
	input  logic [`WORD_W-1:0] mDataIn,
	regBusIf.busSide           regBus,
	output logic [`WORD_W-1:0] busMuxOut,
	output logic [`WORD_W-1:0] address
);

	localparam logic [2:0] selNone = 3'd0;
	localparam logic [2:0] selPc = 3'd1;
	localparam logic [2:0] selZHigh = 3'd2;
	localparam logic [2:0] selZLow = 3'd3;
	localparam logic [2:0] selMdr = 3'd4;
	localparam logic [2:0] selHi = 3'd5;
	localparam logic [2:0] selLo = 3'd6;
	localparam logic [2:0] selReg = 3'd7;  // register or constant

	logic [`WORD_W-1:0]   pc;
	logic [`WORD_W-1:0]   mar;
	logic [`WORD_W-1:0]   mdr;
	logic [`WORD_W-1:0]   y;
	logic [`WORD_W-1:0]   hi;
	logic [`WORD_W-1:0]   lo;
	logic [2*`WORD_W-1:0] z;
	logic [2*`WORD_W-1:0] aluResult;
	logic [2:0]           busSel;
	logic [`WORD_W-1:0]   busWord;

	// --------------------------------------------------
	// bus select encoder and mux
	// --------------------------------------------------
	always_comb begin
		busSel = selNone;
		if (pcOut) busSel = selPc;
		else if (zHighOut) busSel = selZHigh;
		else if (zLowOut) busSel = selZLow;
		else if (mdrOut) busSel = selMdr;
		else if (hiOut) busSel = selHi;
		else if (loOut) busSel = selLo;
		else if (regBus.regDrive || regBus.constDrive) busSel = selReg;
	end

	always_comb begin
		case (busSel)
			selPc:    busWord = pc;
			selZHigh: busWord = z[2*`WORD_W-1:`WORD_W];
			selZLow:  busWord = z[`WORD_W-1:0];
			selMdr:   busWord = mdr;
			selHi:    busWord = hi;
			selLo:    busWord = lo;
			selReg:   busWord = regBus.regValue;
			default:  busWord = '0;  // idle bus
		endcase
	end

	alu aluInst (
		.a      (y),
		.b      (busWord),
		.op     (op),
		.result (aluResult)
	);

	// --------------------------------------------------
	// special registers
	// --------------------------------------------------
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			regBus.ir <= '0;
			mar <= '0;
			mdr <= '0;
			y <= '0;
			hi <= '0;
			lo <= '0;
			z <= '0;
		end else begin
			if (pcIn) pc <= incPc ? pc + `WORD_W'(1) : busWord;
			if (irIn) regBus.ir <= busWord;
			if (marIn) mar <= busWord;
			if (mdrIn) mdr <= read ? mDataIn : busWord;  // memory read or bus
			if (yIn) y <= busWord;
			if (hiIn) hi <= busWord;
			if (loIn) lo <= busWord;
			if (zIn) z <= aluResult;  // both halves
		end
	end

	assign regBus.busValue = busWord;
	assign busMuxOut = busWord;
	assign address = mar;

	busOneSource: assert property (@(posedge Clock) disable iff (!rstN)
		$onehot0({pcOut, zHighOut, zLowOut, mdrOut, hiOut, loOut,
			regBus.regDrive, regBus.constDrive}));

	legalAluOp: assert property (@(posedge Clock) disable iff (!rstN)
		zIn |-> op inside {aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShra,
			aluShl, aluRor, aluRol, aluMul, aluNeg, aluNot});

endmodule

// ==== dataPath.sv ====
`timescale 1ns/1ps
`include "datapath_cfg.svh"

module dataPath import datapathPkg::*; (
	input  logic               Clock,
	input  logic               rstN,
	input  logic               pcOut,
	input  logic               zHighOut,
	input  logic               zLowOut,
	input  logic               mdrOut,
	input  logic               hiOut,
	input  logic               loOut,
	input  logic               pcIn,
	input  logic               irIn,
	input  logic               marIn,
	input  logic               mdrIn,
	input  logic               yIn,
	input  logic               hiIn,
	input  logic               loIn,
	input  logic               zIn,
	input  logic               incPc,
	input  logic               read,
	input  logic               gra,
	input  logic               grb,
	input  logic               grc,
	input  logic               rIn,
	input  logic               rOut,
	input  logic               baOut,
	input  logic               cOut,
	input  aluOpT              aluOp,
	input  logic [`WORD_W-1:0] mDataIn,
	output logic [`WORD_W-1:0] busMuxOut,
	output logic [`WORD_W-1:0] address
);

	regBusIf regBus ();

	// --------------------------------------------------
	// general registers
	// --------------------------------------------------
	regFile regFileInst (
		.Clock  (Clock),
		.rstN   (rstN),
		.gra    (gra),
		.grb    (grb),
		.grc    (grc),
		.rIn    (rIn),
		.rOut   (rOut),
		.baOut  (baOut),
		.cOut   (cOut),
		.regBus (regBus.regSide)
	);

	// --------------------------------------------------
	// bus, special registers and ALU
	// --------------------------------------------------
	busUnit busUnitInst (
		.Clock     (Clock),
		.rstN      (rstN),
		.pcOut     (pcOut),
		.zHighOut  (zHighOut),
		.zLowOut   (zLowOut),
		.mdrOut    (mdrOut),
		.hiOut     (hiOut),
		.loOut     (loOut),
		.pcIn      (pcIn),
		.irIn      (irIn),
		.marIn     (marIn),
		.mdrIn     (mdrIn),
		.yIn       (yIn),
		.hiIn      (hiIn),
		.loIn      (loIn),
		.zIn       (zIn),
		.incPc     (incPc),
		.read      (read),
		.op        (aluOp),
		.mDataIn   (mDataIn),
		.regBus    (regBus.busSide),
		.busMuxOut (busMuxOut),
		.address   (address)
	);

endmodule

// ==== tbDataPath.sv ====
`timescale 1ns/1ps
`include "datapath_cfg.svh"

module tbDataPath import datapathPkg::*; ();

	localparam int maxSteps = 128;
	localparam int resetCycles = 3;
	localparam int testCount = 6;

	logic               Clock = 1'b0;
	logic               rstN;
	logic [27:0]        ctrl;      // strobes, selects and ALU op
	logic [`WORD_W-1:0] mData;
	logic [`WORD_W-1:0] busMuxOut;
	logic [`WORD_W-1:0] address;

	logic [31:0] golden [4*maxSteps];  // four words per step
	int nSteps;
	int timeoutLimit = 2 * maxSteps;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testIdx = 0;
	int testChecks = 0;
	int testErrors = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	always #10 Clock = ~Clock;

	dataPath UUT (
		.Clock     (Clock),
		.rstN      (rstN),
		.pcOut     (ctrl[27]),
		.zHighOut  (ctrl[26]),
		.zLowOut   (ctrl[25]),
		.mdrOut    (ctrl[24]),
		.hiOut     (ctrl[23]),
		.loOut     (ctrl[22]),
		.pcIn      (ctrl[21]),
		.irIn      (ctrl[20]),
		.marIn     (ctrl[19]),
		.mdrIn     (ctrl[18]),
		.yIn       (ctrl[17]),
		.hiIn      (ctrl[16]),
		.loIn      (ctrl[15]),
		.zIn       (ctrl[14]),
		.incPc     (ctrl[13]),
		.read      (ctrl[12]),
		.gra       (ctrl[11]),
		.grb       (ctrl[10]),
		.grc       (ctrl[9]),
		.rIn       (ctrl[8]),
		.rOut      (ctrl[7]),
		.baOut     (ctrl[6]),
		.cOut      (ctrl[5]),
		.aluOp     (aluOpT'(ctrl[4:0])),
		.mDataIn   (mData),
		.busMuxOut (busMuxOut),
		.address   (address)
	);

	// --------------------------------------------------
	// checks and per-test summary
	// --------------------------------------------------
	function automatic string testLabel(input int idx);
		case (idx)
			0: return "reset";
			1: return "register load through MDR";
			2: return "ALU operations";
			3: return "multiply, HI and LO";
			4: return "PC and MAR";
			5: return "IR decodings";
			default: return "extra test";
		endcase
	endfunction

	task automatic checkValue(input int step, input string what,
		input logic [31:0] actual, input logic [31:0] expected);
		checkCount++;
		testChecks++;
		assert (actual === expected) else begin
			$display("error at %0t ns: step %0d %s is %h, expected %h",
				$time, step, what, actual, expected);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic endTest();
		if (testErrors == 0) begin
			testsPassed++;
			$display("test %0d, %s: pass, %0d checks", testIdx + 1, testLabel(testIdx), testChecks);
		end else begin
			testsFailed++;
			$display("test %0d, %s: fail, %0d of %0d checks wrong",
				testIdx + 1, testLabel(testIdx), testErrors, testChecks);
		end
		testIdx++;
		testChecks = 0;
		testErrors = 0;
	endtask

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > timeoutLimit) begin
			$display("timeout: run did not end within %0d cycles", timeoutLimit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// golden step player
	// --------------------------------------------------
	initial begin
		logic [31:0] expected;
		logic [31:0] flags;

		rstN <= 1'b0;
		ctrl <= '0;
		mData <= '0;
		$readmemh("dataPathGolden.mem", golden);
		nSteps = 0;
		while (nSteps < maxSteps && golden[4*nSteps] != 32'hffffffff) begin
			nSteps++;  // stop at end marker
		end
		timeoutLimit = 2 * nSteps + resetCycles;
		if (nSteps == 0 || nSteps == maxSteps) begin
			$display("no end marker or no steps found in dataPathGolden.mem");
			$display("CHECKS FAILED");
		end else begin
			repeat (resetCycles) @(posedge Clock);
			rstN <= 1'b1;
			for (int step = 0; step < nSteps; step++) begin
				@(posedge Clock);
				ctrl <= golden[4*step][27:0];
				mData <= golden[4*step+1];
				expected = golden[4*step+2];
				flags = golden[4*step+3];
				@(negedge Clock);  // bus settled
				if (flags[0]) checkValue(step, "bus", busMuxOut, expected);
				if (flags[1]) checkValue(step, "address", address, expected);
				if (flags[4]) endTest();
			end
			$display("tests passed %0d, failed %0d; checks %0d, errors %0d",
				testsPassed, testsFailed, checkCount, errorCount);
			if (errorCount == 0 && checkCount > 0 && testIdx == testCount) begin
				$display("ALL CHECKS PASSED");
			end else begin
				if (testIdx != testCount) begin
					$display("golden file held %0d tests instead of %0d", testIdx, testCount);
				end
				$display("CHECKS FAILED");
			end
		end
		$finish;
	end

endmodule

// ==== dataPathGolden.mem ====
// columns: control word, mDataIn, expected value, flags (bit 0 bus, bit 1 address, bit 4 test end)
// control bits 27..5: pcOut zHi zLo mdrOut hiOut loOut pcIn irIn marIn mdrIn yIn hiIn loIn
//   zIn incPc read gra grb grc rIn rOut baOut cOut, bits 4..0 aluOp
// test 1, every source reads zero after reset
08000000 00000000 00000000 01
04000000 00000000 00000000 01
02000000 00000000 00000000 01
01000000 00000000 00000000 01
00800000 00000000 00000000 01
00400000 00000000 00000000 01
00000880 00000000 00000000 01
00000020 00000000 00000000 01
00000000 00000000 00000000 12
// test 2, IR = sub R4 R3 R7, then R4 R3 R7 = 12 18 14
00041000 221b8000 00000000 00
01100000 00000000 221b8000 01
00041000 00000012 00000000 00
01000900 00000000 00000012 01
00041000 00000018 00000000 00
01000500 00000000 00000018 01
00041000 00000014 00000000 00
01000300 00000000 00000014 01
00000880 00000000 00000012 01
00000480 00000000 00000018 01
00000280 00000000 00000014 11
// test 3, Y = R3, each op with R7 on the bus
00020480 00000000 00000018 01
00004284 00000000 00000014 01
02000900 00000000 00000004 01
00000880 00000000 00000004 01
00004283 00000000 00000000 00
02000000 00000000 0000002c 01
00004285 00000000 00000000 00
02000000 00000000 00000010 01
00004286 00000000 00000000 00
02000000 00000000 0000001c 01
00004289 00000000 00000000 00
02000000 00000000 01800000 01
0000428a 00000000 00000000 00
02000000 00000000 00018000 01
00004291 00000000 00000000 00
02000000 00000000 ffffffec 11
// test 4, 12345678 times ffff0000 signed
00041000 12345678 00000000 00
01020000 00000000 12345678 01
00041000 ffff0000 00000000 00
0100400f 00000000 ffff0000 01
04010000 00000000 ffffedcb 01
02008000 00000000 a9880000 01
00800000 00000000 ffffedcb 01
00400000 00000000 a9880000 11
// test 5, PC = 100, MAR gets old PC
00041000 00000100 00000000 00
01200000 00000000 00000100 01
08080000 00000000 00000100 01
00202000 00000000 00000100 02
08000000 00000000 00000101 11
// test 6, immediate IR with c = -5 and ra = 0
00041000 182ffffb 00000000 00
01100000 00000000 182ffffb 01
00000020 00000000 fffffffb 01
00041000 00000055 00000000 00
01000900 00000000 00000055 01
00000880 00000000 00000055 01
00000840 00000000 00000000 11
// end marker
ffffffff 00000000 00000000 00

// ==== project.f ====
+incdir+.
datapathPkg.sv
regBusIf.sv
regFile.sv
alu.sv
busUnit.sv
dataPath.sv
tbDataPath.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbDataPath
FILELIST  ?= project.f
GOLDEN    ?= dataPathGolden.mem
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM) $(GOLDEN)
	./$(SIM) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || \
		{ echo "simulation ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
